// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and register file
`define CPU_XLEN 32
`define CPU_REG_COUNT 32

// word addresses of the two memories
`define CPU_IMEM_ADDR_WIDTH 16
`define CPU_DMEM_ADDR_WIDTH 8

`endif

// ==== cpu_pkg.sv ====
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_addr_t;
	typedef logic [`CPU_IMEM_ADDR_WIDTH-1:0] imem_addr_t;
	typedef logic [`CPU_DMEM_ADDR_WIDTH-1:0] dmem_addr_t;

	// condition codes, bit positions inside flags_t
	typedef logic [2:0] flags_t;
	localparam int FLAG_ZERO = 2;
	localparam int FLAG_SIGN = 1;
	localparam int FLAG_OVER = 0;

	// operand sources in execute
	localparam logic [1:0] FWD_REG = 2'd0;
	localparam logic [1:0] FWD_EXMEM = 2'd1;
	localparam logic [1:0] FWD_MEMWB = 2'd2;

	typedef enum logic [4:0] {
		OP_ADD = 5'b00000,
		OP_ADDI = 5'b00001,
		OP_SUB = 5'b00010,
		OP_AND = 5'b00011,
		OP_ANDI = 5'b00100,
		OP_OR = 5'b00101,
		OP_ORI = 5'b00110,
		OP_XOR = 5'b00111,
		OP_SLL = 5'b01000,
		OP_SRL = 5'b01001,
		OP_SRA = 5'b01010,
		OP_LOAD = 5'b01111,
		OP_STORE = 5'b10000,
		OP_B = 5'b10001
	} opcode_e;

	// low four bits of the ALU opcodes
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_ADDI = 4'd1,
		ALU_SUB = 4'd2,
		ALU_AND = 4'd3,
		ALU_ANDI = 4'd4,
		ALU_OR = 4'd5,
		ALU_ORI = 4'd6,
		ALU_XOR = 4'd7,
		ALU_SLL = 4'd8,
		ALU_SRL = 4'd9,
		ALU_SRA = 4'd10
	} alu_op_e;

	typedef enum logic [2:0] {
		COND_NE = 3'd0,
		COND_EQ = 3'd1,
		COND_GT = 3'd2,
		COND_LT = 3'd3,
		COND_GE = 3'd4,
		COND_LE = 3'd5,
		COND_OVER = 3'd6,
		COND_ALWAYS = 3'd7
	} cond_e;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
`default_nettype none

module fetch_stage (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire flush,
	input wire branch_taken,
	input wire cpu_pkg::imem_addr_t branch_target,
	input wire cpu_pkg::word_t instr,
	output cpu_pkg::imem_addr_t instr_addr,
	output cpu_pkg::imem_addr_t ifid_pc,
	output cpu_pkg::word_t ifid_instr,
	output logic ifid_valid
);
	import cpu_pkg::*;

	imem_addr_t pc;

	assign instr_addr = pc;

	// program counter, one word per instruction
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else if (!stall) begin
			pc <= pc + imem_addr_t'(1);
		end
	end

	// IF/ID, a flush beats a stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ifid_valid <= 1'b0;
		end else if (flush) begin
			ifid_valid <= 1'b0;
		end else if (!stall) begin
			ifid_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifid_instr <= instr;
			ifid_pc <= pc;
		end
	end

endmodule

`default_nettype wire

// ==== register_file.sv ====
`default_nettype none

`include "cpu_macros.svh"

module register_file (
	input wire clk,
	input wire rst_n,
	input wire cpu_pkg::reg_addr_t rs1,
	input wire cpu_pkg::reg_addr_t rs2,
	input wire cpu_pkg::reg_addr_t rd,
	input wire we,
	input wire cpu_pkg::word_t wdata,
	output cpu_pkg::word_t rdata1,
	output cpu_pkg::word_t rdata2
);
	import cpu_pkg::*;

	word_t regs [`CPU_REG_COUNT];

	// r0 is never written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// writeback in the same cycle is seen by decode
	function automatic word_t read_port(reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (we && rd == addr) begin
			return wdata;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdata1 = read_port(rs1);
		rdata2 = read_port(rs2);
	end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none

module decode_stage (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire ifid_valid,
	input wire cpu_pkg::word_t ifid_instr,
	input wire cpu_pkg::imem_addr_t ifid_pc,
	input wire cpu_pkg::flags_t flags,
	input wire cpu_pkg::word_t rdata1,
	input wire cpu_pkg::word_t rdata2,
	output cpu_pkg::reg_addr_t rs1,
	output cpu_pkg::reg_addr_t rs2,
	output logic id_cond_branch,
	output logic branch_taken,
	output cpu_pkg::imem_addr_t branch_target,
	output cpu_pkg::word_t idex_a,
	output cpu_pkg::word_t idex_b,
	output cpu_pkg::word_t idex_imm,
	output cpu_pkg::reg_addr_t idex_rs1,
	output cpu_pkg::reg_addr_t idex_rs2,
	output cpu_pkg::reg_addr_t idex_rd,
	output cpu_pkg::alu_op_e idex_alu_op,
	output logic idex_use_imm,
	output logic idex_set_flags,
	output logic idex_load,
	output logic idex_store,
	output logic idex_write
);
	import cpu_pkg::*;

	opcode_e opcode;
	cond_e cond;
	reg_addr_t rd;
	word_t imm;
	alu_op_e alu_op;
	logic use_imm, set_flags, load, store, write, is_branch;
	logic cond_true;

	assign opcode = opcode_e'(ifid_instr[31:27]);
	assign cond = cond_e'(ifid_instr[26:24]);
	assign rd = ifid_instr[26:22];
	assign rs1 = ifid_instr[21:17];
	// store data comes from rd
	assign rs2 = (opcode == OP_STORE) ? rd : ifid_instr[16:12];
	assign imm = word_t'($signed(ifid_instr[15:0]));

	//////////////////////////////////////////////////////////////////////
	// control decode

	always_comb begin
		alu_op = ALU_ADD;
		use_imm = 1'b0;
		set_flags = 1'b0;
		load = 1'b0;
		store = 1'b0;
		write = 1'b0;
		is_branch = 1'b0;
		case (opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: begin
				alu_op = alu_op_e'(ifid_instr[30:27]);
				set_flags = 1'b1;
				write = 1'b1;
			end
			OP_ADDI, OP_ANDI, OP_ORI: begin
				alu_op = alu_op_e'(ifid_instr[30:27]);
				use_imm = 1'b1;
				set_flags = 1'b1;
				write = 1'b1;
			end
			OP_LOAD: begin
				use_imm = 1'b1;
				load = 1'b1;
				write = 1'b1;
			end
			OP_STORE: begin
				use_imm = 1'b1;
				store = 1'b1;
			end
			OP_B: begin
				is_branch = 1'b1;
			end
			// anything else is a no-op
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// branch resolution

	always_comb begin
		case (cond)
			COND_NE: cond_true = !flags[FLAG_ZERO];
			COND_EQ: cond_true = flags[FLAG_ZERO];
			COND_GT: cond_true = !flags[FLAG_ZERO] && !flags[FLAG_SIGN];
			COND_LT: cond_true = !flags[FLAG_ZERO] && flags[FLAG_SIGN];
			COND_GE: cond_true = flags[FLAG_ZERO] || !flags[FLAG_SIGN];
			COND_LE: cond_true = flags[FLAG_ZERO] || flags[FLAG_SIGN];
			COND_OVER: cond_true = flags[FLAG_OVER];
			default: cond_true = 1'b1;
		endcase
	end

	assign id_cond_branch = ifid_valid && is_branch && cond != COND_ALWAYS;
	// flags may still be stale while stalled
	assign branch_taken = ifid_valid && is_branch && cond_true && !stall;
	assign branch_target = ifid_pc + imem_addr_t'(1) + imem_addr_t'(imm);

	//////////////////////////////////////////////////////////////////////
	// ID/EX

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idex_set_flags <= 1'b0;
			idex_load <= 1'b0;
			idex_store <= 1'b0;
			idex_write <= 1'b0;
		end else if (stall || !ifid_valid) begin
			idex_set_flags <= 1'b0;
			idex_load <= 1'b0;
			idex_store <= 1'b0;
			idex_write <= 1'b0;
		end else begin
			idex_set_flags <= set_flags;
			idex_load <= load;
			idex_store <= store;
			idex_write <= write;
		end
	end

	always_ff @(posedge clk) begin
		idex_a <= rdata1;
		idex_b <= rdata2;
		idex_imm <= imm;
		idex_rs1 <= rs1;
		idex_rs2 <= rs2;
		idex_rd <= rd;
		idex_alu_op <= alu_op;
		idex_use_imm <= use_imm;
	end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none

module execute_stage (
	input wire clk,
	input wire rst_n,
	input wire cpu_pkg::word_t idex_a,
	input wire cpu_pkg::word_t idex_b,
	input wire cpu_pkg::word_t idex_imm,
	input wire cpu_pkg::reg_addr_t idex_rd,
	input wire cpu_pkg::alu_op_e idex_alu_op,
	input wire idex_use_imm,
	input wire idex_set_flags,
	input wire idex_load,
	input wire idex_store,
	input wire idex_write,
	input wire [1:0] fwd_a,
	input wire [1:0] fwd_b,
	input wire cpu_pkg::word_t memwb_data,
	output cpu_pkg::flags_t flags,
	output cpu_pkg::word_t exmem_result,
	output cpu_pkg::word_t exmem_store_data,
	output cpu_pkg::reg_addr_t exmem_rd,
	output logic exmem_load,
	output logic exmem_store,
	output logic exmem_write
);
	import cpu_pkg::*;

	localparam int MSB = $bits(word_t) - 1;

	word_t op_a, op_b_reg, op_b, result;
	logic overflow;
	flags_t flags_next;

	function automatic word_t forward(logic [1:0] sel, word_t reg_value);
		case (sel)
			FWD_EXMEM: return exmem_result;
			FWD_MEMWB: return memwb_data;
			default: return reg_value;
		endcase
	endfunction

	always_comb begin
		op_a = forward(fwd_a, idex_a);
		op_b_reg = forward(fwd_b, idex_b);
		op_b = idex_use_imm ? idex_imm : op_b_reg;
	end

	//////////////////////////////////////////////////////////////////////
	// ALU

	always_comb begin
		result = '0;
		overflow = 1'b0;
		case (idex_alu_op)
			ALU_ADD, ALU_ADDI: begin
				result = op_a + op_b;
				overflow = (op_a[MSB] == op_b[MSB]) && (result[MSB] != op_a[MSB]);
			end
			ALU_SUB: begin
				result = op_a - op_b;
				overflow = (op_a[MSB] != op_b[MSB]) && (result[MSB] != op_a[MSB]);
			end
			ALU_AND, ALU_ANDI: result = op_a & op_b;
			ALU_OR, ALU_ORI: result = op_a | op_b;
			ALU_XOR: result = op_a ^ op_b;
			// shift amount from the low five bits
			ALU_SLL: result = op_a << op_b[4:0];
			ALU_SRL: result = op_a >> op_b[4:0];
			ALU_SRA: result = word_t'($signed(op_a) >>> op_b[4:0]);
			default: ;
		endcase
	end

	always_comb begin
		flags_next[FLAG_ZERO] = (result == '0);
		flags_next[FLAG_SIGN] = result[MSB];
		flags_next[FLAG_OVER] = overflow;
	end

	// condition codes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (idex_set_flags) begin
			flags <= flags_next;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// EX/MEM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exmem_load <= 1'b0;
			exmem_store <= 1'b0;
			exmem_write <= 1'b0;
		end else begin
			exmem_load <= idex_load;
			exmem_store <= idex_store;
			exmem_write <= idex_write;
		end
	end

	always_ff @(posedge clk) begin
		exmem_result <= result;
		exmem_store_data <= op_b_reg;
		exmem_rd <= idex_rd;
	end

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
`default_nettype none

`include "cpu_macros.svh"

module memory_stage (
	input wire clk,
	input wire rst_n,
	input wire cpu_pkg::word_t exmem_result,
	input wire cpu_pkg::word_t exmem_store_data,
	input wire cpu_pkg::reg_addr_t exmem_rd,
	input wire exmem_load,
	input wire exmem_store,
	input wire exmem_write,
	output cpu_pkg::word_t memwb_data,
	output cpu_pkg::reg_addr_t memwb_rd,
	output logic memwb_write
);
	import cpu_pkg::*;

	localparam int DMEM_DEPTH = 1 << `CPU_DMEM_ADDR_WIDTH;

	word_t mem [DMEM_DEPTH];
	dmem_addr_t addr;
	word_t rdata;

	// word address from the low bits of rs1 + imm
	assign addr = exmem_result[`CPU_DMEM_ADDR_WIDTH-1:0];
	assign rdata = mem[addr];

	always_ff @(posedge clk) begin
		if (exmem_store) begin
			mem[addr] <= exmem_store_data;
		end
	end

	// MEM/WB
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			memwb_write <= 1'b0;
		end else begin
			memwb_write <= exmem_write;
		end
	end

	always_ff @(posedge clk) begin
		memwb_data <= exmem_load ? rdata : exmem_result;
		memwb_rd <= exmem_rd;
	end

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`default_nettype none

module hazard_unit (
	input wire cpu_pkg::reg_addr_t rs1,
	input wire cpu_pkg::reg_addr_t rs2,
	input wire cpu_pkg::reg_addr_t idex_rs1,
	input wire cpu_pkg::reg_addr_t idex_rs2,
	input wire cpu_pkg::reg_addr_t idex_rd,
	input wire cpu_pkg::reg_addr_t exmem_rd,
	input wire cpu_pkg::reg_addr_t memwb_rd,
	input wire id_cond_branch,
	input wire idex_load,
	input wire idex_set_flags,
	input wire idex_write,
	input wire exmem_write,
	input wire exmem_load,
	input wire memwb_write,
	output logic [1:0] fwd_a,
	output logic [1:0] fwd_b,
	output logic stall
);
	import cpu_pkg::*;

	logic load_use, flag_wait;

	// youngest producer wins, a load in EX/MEM has no data yet
	function automatic logic [1:0] fwd_select(reg_addr_t src);
		if (exmem_write && !exmem_load && exmem_rd != '0 && exmem_rd == src) begin
			return FWD_EXMEM;
		end
		if (memwb_write && memwb_rd != '0 && memwb_rd == src) begin
			return FWD_MEMWB;
		end
		return FWD_REG;
	endfunction

	always_comb begin
		fwd_a = fwd_select(idex_rs1);
		fwd_b = fwd_select(idex_rs2);
	end

	assign load_use = idex_load && idex_write && idex_rd != '0
		&& (idex_rd == rs1 || idex_rd == rs2);
	// flags are written at the end of EX
	assign flag_wait = id_cond_branch && idex_set_flags;
	assign stall = load_use || flag_wait;

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`default_nettype none

module cpu_top (
	input wire clk,
	input wire rst_n,
	output cpu_pkg::imem_addr_t instr_addr,
	input wire cpu_pkg::word_t instr,
	output logic wb_valid,
	output cpu_pkg::reg_addr_t wb_reg,
	output cpu_pkg::word_t wb_data
);
	import cpu_pkg::*;

	logic stall, branch_taken, id_cond_branch;
	imem_addr_t branch_target, ifid_pc;
	word_t ifid_instr;
	logic ifid_valid;

	reg_addr_t rs1, rs2;
	word_t rdata1, rdata2;
	flags_t flags;

	word_t idex_a, idex_b, idex_imm;
	reg_addr_t idex_rs1, idex_rs2, idex_rd;
	alu_op_e idex_alu_op;
	logic idex_use_imm, idex_set_flags, idex_load, idex_store, idex_write;
	logic [1:0] fwd_a, fwd_b;

	word_t exmem_result, exmem_store_data;
	reg_addr_t exmem_rd;
	logic exmem_load, exmem_store, exmem_write;

	word_t memwb_data;
	reg_addr_t memwb_rd;
	logic memwb_write;

	//////////////////////////////////////////////////////////////////////
	// front end

	fetch_stage u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.flush(branch_taken),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.instr(instr),
		.instr_addr(instr_addr),
		.ifid_pc(ifid_pc),
		.ifid_instr(ifid_instr),
		.ifid_valid(ifid_valid)
	);

	register_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.rs1(rs1),
		.rs2(rs2),
		.rd(memwb_rd),
		.we(memwb_write),
		.wdata(memwb_data),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	decode_stage u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.ifid_valid(ifid_valid),
		.ifid_instr(ifid_instr),
		.ifid_pc(ifid_pc),
		.flags(flags),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.rs1(rs1),
		.rs2(rs2),
		.id_cond_branch(id_cond_branch),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.idex_a(idex_a),
		.idex_b(idex_b),
		.idex_imm(idex_imm),
		.idex_rs1(idex_rs1),
		.idex_rs2(idex_rs2),
		.idex_rd(idex_rd),
		.idex_alu_op(idex_alu_op),
		.idex_use_imm(idex_use_imm),
		.idex_set_flags(idex_set_flags),
		.idex_load(idex_load),
		.idex_store(idex_store),
		.idex_write(idex_write)
	);

	hazard_unit u_hazard (
		.rs1(rs1),
		.rs2(rs2),
		.idex_rs1(idex_rs1),
		.idex_rs2(idex_rs2),
		.idex_rd(idex_rd),
		.exmem_rd(exmem_rd),
		.memwb_rd(memwb_rd),
		.id_cond_branch(id_cond_branch),
		.idex_load(idex_load),
		.idex_set_flags(idex_set_flags),
		.idex_write(idex_write),
		.exmem_write(exmem_write),
		.exmem_load(exmem_load),
		.memwb_write(memwb_write),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.stall(stall)
	);

	//////////////////////////////////////////////////////////////////////
	// back end

	execute_stage u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.idex_a(idex_a),
		.idex_b(idex_b),
		.idex_imm(idex_imm),
		.idex_rd(idex_rd),
		.idex_alu_op(idex_alu_op),
		.idex_use_imm(idex_use_imm),
		.idex_set_flags(idex_set_flags),
		.idex_load(idex_load),
		.idex_store(idex_store),
		.idex_write(idex_write),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.memwb_data(memwb_data),
		.flags(flags),
		.exmem_result(exmem_result),
		.exmem_store_data(exmem_store_data),
		.exmem_rd(exmem_rd),
		.exmem_load(exmem_load),
		.exmem_store(exmem_store),
		.exmem_write(exmem_write)
	);

	memory_stage u_memory (
		.clk(clk),
		.rst_n(rst_n),
		.exmem_result(exmem_result),
		.exmem_store_data(exmem_store_data),
		.exmem_rd(exmem_rd),
		.exmem_load(exmem_load),
		.exmem_store(exmem_store),
		.exmem_write(exmem_write),
		.memwb_data(memwb_data),
		.memwb_rd(memwb_rd),
		.memwb_write(memwb_write)
	);

	// retire trace, writes to r0 are dropped
	assign wb_valid = memwb_write && memwb_rd != '0;
	assign wb_reg = memwb_rd;
	assign wb_data = memwb_data;

endmodule

`default_nettype wire

// ==== cpu_asserts.sv ====
`default_nettype none

module cpu_asserts (
	input wire clk,
	input wire rst_n,
	input wire wb_valid,
	input wire cpu_pkg::reg_addr_t wb_reg,
	input wire cpu_pkg::imem_addr_t instr_addr,
	input wire stall
);
	timeunit 1ns;
	timeprecision 100ps;

	// r0 writes are never traced
	wb_reg_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> wb_reg != '0)
		else $error("wb_valid with register 0");

	wb_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_valid)
		else $error("wb_valid high during reset");

	// fetch holds while decode waits
	pc_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(instr_addr))
		else $error("instr_addr moved during a stall");

endmodule

bind cpu_top cpu_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.wb_valid(wb_valid),
	.wb_reg(wb_reg),
	.instr_addr(instr_addr),
	.stall(stall)
);

`default_nettype wire

// ==== tb_cpu.sv ====
`default_nettype none

`include "cpu_macros.svh"

module tb_cpu;
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_pkg::*;

	localparam int PROG_DEPTH = 256;
	localparam int DMEM_DEPTH = 1 << `CPU_DMEM_ADDR_WIDTH;

	logic clk;
	logic rst_n;
	word_t instr;
	imem_addr_t instr_addr;
	logic wb_valid;
	reg_addr_t wb_reg;
	word_t wb_data;

	word_t prog [PROG_DEPTH];
	int prog_len;
	word_t model_mem [DMEM_DEPTH];
	logic [31:0] lfsr_state = 32'h26a6_b30b;

	reg_addr_t exp_reg [$];
	word_t exp_data [$];

	string test_name;
	logic test_active;
	int wd_limit;
	int test_errors;
	int total_errors;
	int tests_run;
	int tests_failed;
	int writes_checked;

	cpu_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.instr_addr(instr_addr),
		.instr(instr),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// instruction ROM answers the settled pc on the falling edge
	always @(negedge clk) begin
		instr <= prog[instr_addr[7:0]];
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic word_t rand_bits(int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic word_t enc_r(opcode_e op, int rd, int rs1, int rs2);
		return {op, 5'(rd), 5'(rs1), 5'(rs2), 12'b0};
	endfunction

	function automatic word_t enc_i(opcode_e op, int rd, int rs1, int imm);
		return {op, 5'(rd), 5'(rs1), 1'b0, 16'(imm)};
	endfunction

	function automatic word_t enc_b(cond_e c, int off);
		return {OP_B, c, 8'b0, 16'(off)};
	endfunction

	task automatic emit(word_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// ISA model that fills the expected write list

	function automatic int run_model();
		word_t regs [32];
		word_t w, a, b, imm, res;
		logic [4:0] op, rd, rs1, rs2;
		logic [2:0] cond;
		logic fz, fs, fv, ov, taken, wr, is_alu;
		longint wide;
		int pc, steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		fz = 1'b0;
		fs = 1'b0;
		fv = 1'b0;
		pc = 0;
		steps = 0;
		while (steps < 2000) begin
			w = prog[pc & 8'hff];
			op = w[31:27];
			rd = w[26:22];
			rs1 = w[21:17];
			rs2 = w[16:12];
			cond = w[26:24];
			imm = {{16{w[15]}}, w[15:0]};
			steps++;
			wr = 1'b0;
			is_alu = 1'b1;
			res = '0;
			a = regs[rs1];
			b = (op == OP_ADDI || op == OP_ANDI || op == OP_ORI) ? imm : regs[rs2];
			ov = 1'b0;
			case (op)
				OP_ADD, OP_ADDI: begin
					res = a + b;
					wide = longint'($signed(a)) + longint'($signed(b));
					ov = wide > 64'sd2147483647 || wide < -64'sd2147483648;
				end
				OP_SUB: begin
					res = a - b;
					wide = longint'($signed(a)) - longint'($signed(b));
					ov = wide > 64'sd2147483647 || wide < -64'sd2147483648;
				end
				OP_AND, OP_ANDI: res = a & b;
				OP_OR, OP_ORI: res = a | b;
				OP_XOR: res = a ^ b;
				OP_SLL: res = a << b[4:0];
				OP_SRL: res = a >> b[4:0];
				OP_SRA: res = $signed(a) >>> b[4:0];
				default: is_alu = 1'b0;
			endcase
			// loads, stores and branches leave the flags alone
			if (is_alu) begin
				fz = (res == 0);
				fs = res[31];
				fv = ov;
				wr = 1'b1;
			end
			pc = (pc + 1) & 16'hffff;
			if (op == OP_LOAD) begin
				res = model_mem[(a + imm) & 8'hff];
				wr = 1'b1;
			end else if (op == OP_STORE) begin
				model_mem[(a + imm) & 8'hff] = regs[rd];
			end else if (op == OP_B) begin
				if (cond == COND_ALWAYS && imm == 32'hffff_ffff) begin
					break;
				end
				case (cond)
					COND_NE: taken = !fz;
					COND_EQ: taken = fz;
					COND_GT: taken = !fz && !fs;
					COND_LT: taken = !fz && fs;
					COND_GE: taken = fz || !fs;
					COND_LE: taken = fz || fs;
					COND_OVER: taken = fv;
					default: taken = 1'b1;
				endcase
				if (taken) begin
					pc = (pc + imm) & 16'hffff;
				end
			end
			if (wr && rd != 0) begin
				regs[rd] = res;
				exp_reg.push_back(rd);
				exp_data.push_back(res);
			end
		end
		return steps;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checking

	task automatic check_value(string what, word_t expected, word_t actual);
		if (expected !== actual) begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (exp_reg.size() == 0) begin
				$display("test %s: r%0d was written after the last expected write",
					test_name, wb_reg);
				test_errors++;
			end else begin
				check_value("register", word_t'(exp_reg[0]), word_t'(wb_reg));
				check_value("data", exp_data[0], wb_data);
				void'(exp_reg.pop_front());
				void'(exp_data.pop_front());
				writes_checked++;
			end
		end
	end

	// stops a test that never drains its write list
	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= wd_limit) begin
			@(posedge clk);
			if (test_active) begin
				cycles++;
			end else begin
				cycles = 0;
			end
		end
		$display("timeout: test %s did not retire all expected writes", test_name);
		$display("Testbench failed");
		$finish;
	end

	task automatic begin_test(string name);
		@(negedge clk);
		test_active = 1'b0;
		rst_n = 1'b0;
		test_name = name;
		test_errors = 0;
		writes_checked = 0;
		exp_reg.delete();
		exp_data.delete();
		for (int i = 0; i < PROG_DEPTH; i++) begin
			prog[i] = '0;
		end
		prog_len = 0;
	endtask

	task automatic run_program();
		int steps;
		// every program parks on a branch to itself
		emit(enc_b(COND_ALWAYS, -1));
		steps = run_model();
		wd_limit = 20 * steps + 20;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		test_active = 1'b1;
		while (exp_reg.size() != 0) begin
			@(negedge clk);
		end
		repeat (10) @(negedge clk);
		test_active = 1'b0;
		$display("test %s: %0d writes checked, %0d errors", test_name, writes_checked,
			test_errors);
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests

	initial begin
		opcode_e rand_ops [9];
		opcode_e op;
		rst_n = 1'b0;
		instr = '0;
		test_active = 1'b0;
		wd_limit = 1000;
		tests_run = 0;
		tests_failed = 0;
		total_errors = 0;
		rand_ops = '{OP_ADDI, OP_ANDI, OP_ORI, OP_SLL, OP_SRL, OP_SRA, OP_ADD, OP_SUB, OP_XOR};

		// dependent chain through both forwarding paths
		begin_test("alu_forwarding");
		emit(enc_i(OP_ADDI, 1, 0, 16'h1234));
		emit(enc_i(OP_ADDI, 2, 0, -5));
		emit(enc_r(OP_ADD, 3, 1, 2));
		emit(enc_r(OP_SUB, 4, 3, 1));
		emit(enc_r(OP_AND, 5, 4, 3));
		emit(enc_r(OP_OR, 6, 5, 2));
		emit(enc_r(OP_XOR, 7, 6, 4));
		emit(enc_r(OP_ADD, 8, 7, 7));
		emit(enc_r(OP_SUB, 9, 8, 3));
		run_program();

		begin_test("imm_shift_random");
		emit(enc_i(OP_ADDI, 3, 0, -300));
		emit(enc_i(OP_ADDI, 4, 0, 5));
		emit(enc_r(OP_SRA, 5, 3, 4));
		emit(enc_r(OP_SRL, 6, 3, 4));
		emit(enc_r(OP_SLL, 7, 3, 4));
		emit(enc_i(OP_ADDI, 1, 0, 16'h8000));
		for (int i = 0; i < 32; i++) begin
			op = rand_ops[rand_bits(4) % 9];
			emit({op, 2'b00, 3'(rand_bits(3)), 5'(rand_bits(5)), 17'(rand_bits(17))});
		end
		run_program();

		begin_test("load_store");
		emit(enc_i(OP_ADDI, 1, 0, 10));
		emit(enc_i(OP_ADDI, 2, 0, 16'h05a5));
		emit(enc_i(OP_ADDI, 3, 0, -77));
		emit(enc_i(OP_STORE, 2, 1, 0));
		emit(enc_i(OP_STORE, 3, 1, 1));
		emit(enc_i(OP_LOAD, 4, 1, 0));
		emit(enc_r(OP_ADD, 5, 4, 4));
		emit(enc_i(OP_LOAD, 6, 1, 1));
		emit(enc_r(OP_SUB, 7, 6, 2));
		emit(enc_i(OP_STORE, 7, 0, 200));
		emit(enc_i(OP_LOAD, 8, 0, 200));
		emit(enc_i(OP_LOAD, 9, 1, 1));
		emit(enc_r(OP_XOR, 10, 8, 9));
		// address wraps to the low eight bits
		emit(enc_i(OP_STORE, 10, 1, 16'h0100));
		emit(enc_i(OP_LOAD, 11, 0, 10));
		emit(enc_i(OP_STORE, 11, 11, 0));
		emit(enc_i(OP_LOAD, 12, 11, 0));
		run_program();

		begin_test("branch_conditions");
		emit(enc_i(OP_ADDI, 1, 0, 5));
		emit(enc_i(OP_ADDI, 2, 0, 5));
		emit(enc_i(OP_ADDI, 3, 0, -3));
		emit(enc_i(OP_ADDI, 5, 0, 31));
		emit(enc_i(OP_ADDI, 4, 0, 1));
		emit(enc_r(OP_SLL, 4, 4, 5));
		for (int c = 0; c < 8; c++) begin
			case (c)
				0, 1: emit(enc_r(OP_SUB, 10, 1, 2));
				2, 3: emit(enc_r(OP_SUB, 10, 1, 3));
				4: emit(enc_r(OP_ADD, 10, 3, 1));
				5: emit(enc_r(OP_SUB, 10, 3, 1));
				6: emit(enc_r(OP_SUB, 10, 4, 1));
				default: emit(enc_r(OP_ADD, 10, 4, 4));
			endcase
			emit(enc_b(cond_e'(c), 1));
			emit(enc_i(OP_ADDI, 20, 0, 16'h0100 + c));
			emit(enc_i(OP_ADDI, 21, 0, 16'h0200 + c));
		end
		// second pass with the opposite outcomes
		emit(enc_r(OP_ADD, 10, 1, 2));
		emit(enc_b(COND_OVER, 1));
		emit(enc_i(OP_ADDI, 20, 0, 16'h0300));
		emit(enc_r(OP_SUB, 10, 3, 1));
		emit(enc_b(COND_GE, 1));
		emit(enc_i(OP_ADDI, 20, 0, 16'h0301));
		emit(enc_r(OP_ADD, 10, 1, 2));
		emit(enc_b(COND_LT, 1));
		emit(enc_i(OP_ADDI, 20, 0, 16'h0302));
		run_program();

		begin_test("register_zero");
		emit(enc_i(OP_ADDI, 0, 0, 123));
		emit(enc_i(OP_ADDI, 1, 0, 7));
		emit(enc_r(OP_ADD, 0, 1, 1));
		emit(enc_r(OP_ADD, 2, 0, 1));
		emit(enc_r(OP_SUB, 0, 1, 2));
		emit(enc_r(OP_OR, 3, 0, 0));
		emit(enc_i(OP_STORE, 1, 0, 50));
		emit(enc_i(OP_LOAD, 0, 0, 50));
		emit(enc_r(OP_ADD, 4, 0, 1));
		// undefined opcode behaves as a no-op
		emit({5'b11111, 5'd5, 5'd1, 17'h1_2345});
		emit(enc_r(OP_ADD, 6, 5, 1));
		run_program();

		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
cpu_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
cpu_top.sv
cpu_asserts.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_cpu -f build.f -o tb_cpu_sim

./obj_dir/tb_cpu_sim | tee sim.log

grep -q "^Testbench passed$" sim.log
echo "simulation passed"
